//--- logic/rv_decode_macros.svh
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// ------------------
// datapath sizes
// ------------------

`define XLEN 32         // data and address width.

`define NREGS 32        // integer register count.

`define RADDR_W 5       // register index width.

`endif

//--- logic/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_macros.svh"

package rv_decode_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`RADDR_W-1:0] regaddr_t;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_fence  = 7'b0001111,
        op_system = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass
    } alu_op_t;

    typedef enum logic [3:0] {
        except_illegal_instruction = 4'd2,
        except_breakpoint          = 4'd3,
        except_env_call_mach       = 4'd11
    } ecause_t;

    typedef struct packed {
        word_t    imm;
        regaddr_t waddr;
        regaddr_t raddr1;
        regaddr_t raddr2;
        logic     wren;
        logic     rden1;
        logic     rden2;
        logic     auipc;
        logic     lui;
        logic     jal;
        logic     jalr;
        logic     branch;
        logic     load;
        logic     store;
        logic     fence;
        logic     ecall;
        logic     ebreak;
        logic     valid;
        alu_op_t  alu_op;
    } decoded_t;

endpackage

`default_nettype wire

//--- logic/rv_decode_stage.sv
`default_nettype none

`include "rv_decode_macros.svh"

module rv_decode_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  logic [`XLEN-1:0]         in_pc,
    input  logic [`XLEN-1:0]         in_instr,
    input  logic                     flush,
    input  rv_decode_pkg::decoded_t  dec,
    output logic [`XLEN-1:0]         instr_out,
    rv_read_if.stage                 rd,
    output logic                     stall,
    output logic                     out_valid,
    output logic [`XLEN-1:0]         out_pc,
    output logic [`XLEN-1:0]         out_npc,
    output logic [`XLEN-1:0]         out_imm,
    output logic [`RADDR_W-1:0]      out_waddr,
    output logic                     out_wren,
    output logic [`XLEN-1:0]         out_rdata1,
    output logic [`XLEN-1:0]         out_rdata2,
    output rv_decode_pkg::alu_op_t   out_alu_op,
    output logic                     out_load,
    output logic                     out_store,
    output logic                     out_branch,
    output logic                     out_jal,
    output logic                     out_jalr,
    output logic                     out_exception,
    output rv_decode_pkg::ecause_t   out_ecause,
    output logic [`XLEN-1:0]         out_etval
);
    import rv_decode_pkg::*;

    logic    hazard;
    logic    kill;
    logic    exc;
    ecause_t cause;

    assign instr_out = in_instr;

    assign rd.rden1 = dec.rden1;
    assign rd.rden2 = dec.rden2;
    assign rd.raddr1 = dec.raddr1;
    assign rd.raddr2 = dec.raddr2;

    // ------------------
    // hazard and bubble
    // ------------------
    assign hazard = out_load && (out_waddr != '0) &&
                    ((dec.rden1 && dec.raddr1 == out_waddr) ||
                     (dec.rden2 && dec.raddr2 == out_waddr));
    assign stall = in_valid && hazard && !flush;   // flush wins.
    assign kill = !in_valid || stall || flush;

    always_comb begin
        exc = 1'b1;
        cause = except_illegal_instruction;
        if (!dec.valid)
            cause = except_illegal_instruction;
        else if (dec.ebreak)
            cause = except_breakpoint;
        else if (dec.ecall)
            cause = except_env_call_mach;
        else
            exc = 1'b0;
    end

    // ------------------
    // output register
    // ------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
            out_exception <= 1'b0;
            out_wren <= 1'b0;
            out_load <= 1'b0;
            out_store <= 1'b0;
            out_branch <= 1'b0;
            out_jal <= 1'b0;
            out_jalr <= 1'b0;
        end else begin
            out_valid <= !kill && dec.valid;
            out_exception <= !kill && exc;
            out_wren <= !kill && !exc && dec.wren;   // trap never writes back.
            out_load <= !kill && !exc && dec.load;
            out_store <= !kill && !exc && dec.store;
            out_branch <= !kill && dec.branch;
            out_jal <= !kill && dec.jal;
            out_jalr <= !kill && dec.jalr;
        end
    end

    always_ff @(posedge clk) begin
        out_pc <= in_pc;
        out_npc <= in_pc + `XLEN'd4;
        out_imm <= dec.imm;
        out_waddr <= dec.waddr;
        out_rdata1 <= rd.data1;
        out_rdata2 <= rd.data2;
        out_alu_op <= dec.alu_op;
        out_ecause <= cause;
        out_etval <= in_instr;
    end

endmodule

`default_nettype wire

//--- logic/rv_decode_top.sv
`default_nettype none

`include "rv_decode_macros.svh"

module rv_decode_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic [`XLEN-1:0]        in_pc,
    input  logic [`XLEN-1:0]        in_instr,
    input  logic                    ex_wren,
    input  logic                    ex_load,
    input  logic [`RADDR_W-1:0]     ex_waddr,
    input  logic [`XLEN-1:0]        ex_wdata,
    input  logic                    wb_wren,
    input  logic [`RADDR_W-1:0]     wb_waddr,
    input  logic [`XLEN-1:0]        wb_wdata,
    input  logic                    flush,
    output logic                    stall,
    output logic                    out_valid,
    output logic [`XLEN-1:0]        out_pc,
    output logic [`XLEN-1:0]        out_npc,
    output logic [`XLEN-1:0]        out_imm,
    output logic [`RADDR_W-1:0]     out_waddr,
    output logic                    out_wren,
    output logic [`XLEN-1:0]        out_rdata1,
    output logic [`XLEN-1:0]        out_rdata2,
    output rv_decode_pkg::alu_op_t  out_alu_op,
    output logic                    out_load,
    output logic                    out_store,
    output logic                    out_branch,
    output logic                    out_jal,
    output logic                    out_jalr,
    output logic                    out_exception,
    output rv_decode_pkg::ecause_t  out_ecause,
    output logic [`XLEN-1:0]        out_etval
);
    import rv_decode_pkg::*;

    decoded_t dec;
    word_t    instr;

    rv_read_if rd_bus ();

    rv_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    rv_regfile u_regfile (
        .clk   (clk),
        .rst   (rst),
        .rd    (rd_bus.regfile),
        .wren  (wb_wren),
        .waddr (wb_waddr),
        .wdata (wb_wdata)
    );

    rv_forward u_forward (
        .rd       (rd_bus.bypass),
        .ex_wren  (ex_wren),
        .ex_load  (ex_load),
        .ex_waddr (ex_waddr),
        .ex_wdata (ex_wdata),
        .wb_wren  (wb_wren),
        .wb_waddr (wb_waddr),
        .wb_wdata (wb_wdata)
    );

    rv_decode_stage u_stage (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_pc         (in_pc),
        .in_instr      (in_instr),
        .flush         (flush),
        .dec           (dec),
        .instr_out     (instr),
        .rd            (rd_bus.stage),
        .stall         (stall),
        .out_valid     (out_valid),
        .out_pc        (out_pc),
        .out_npc       (out_npc),
        .out_imm       (out_imm),
        .out_waddr     (out_waddr),
        .out_wren      (out_wren),
        .out_rdata1    (out_rdata1),
        .out_rdata2    (out_rdata2),
        .out_alu_op    (out_alu_op),
        .out_load      (out_load),
        .out_store     (out_store),
        .out_branch    (out_branch),
        .out_jal       (out_jal),
        .out_jalr      (out_jalr),
        .out_exception (out_exception),
        .out_ecause    (out_ecause),
        .out_etval     (out_etval)
    );

endmodule

`default_nettype wire

//--- logic/rv_decoder.sv
`default_nettype none

`include "rv_decode_macros.svh"

module rv_decoder (
    input  logic [`XLEN-1:0]       instr,
    output rv_decode_pkg::decoded_t dec
);
    import rv_decode_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_t    arith_op;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // ------------------
    // immediate formats
    // ------------------
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  arith_op = alu_add;   // sub picked below for op_reg.
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = funct7[5] ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        dec = '0;
        dec.waddr = instr[11:7];
        dec.raddr1 = instr[19:15];
        dec.raddr2 = instr[24:20];
        case (opcode_t'(instr[6:0]))
            op_lui: begin
                dec.imm = imm_u;
                dec.wren = 1'b1;
                dec.lui = 1'b1;
                dec.alu_op = alu_pass;
                dec.valid = 1'b1;
            end
            op_auipc: begin
                dec.imm = imm_u;
                dec.wren = 1'b1;
                dec.auipc = 1'b1;
                dec.valid = 1'b1;
            end
            op_jal: begin
                dec.imm = imm_j;
                dec.wren = 1'b1;
                dec.jal = 1'b1;
                dec.valid = 1'b1;
            end
            op_jalr: begin
                dec.imm = imm_i;
                dec.wren = 1'b1;
                dec.rden1 = 1'b1;
                dec.jalr = 1'b1;
                dec.valid = (funct3 == 3'b000);
            end
            op_branch: begin
                dec.imm = imm_b;
                dec.rden1 = 1'b1;
                dec.rden2 = 1'b1;
                dec.branch = 1'b1;
                dec.valid = (funct3[2:1] != 2'b01);
            end
            op_load: begin
                dec.imm = imm_i;
                dec.wren = 1'b1;
                dec.rden1 = 1'b1;
                dec.load = 1'b1;
                dec.valid = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
            end
            op_store: begin
                dec.imm = imm_s;
                dec.rden1 = 1'b1;
                dec.rden2 = 1'b1;
                dec.store = 1'b1;
                dec.valid = (funct3[2] == 1'b0) && (funct3 != 3'b011);
            end
            op_imm: begin
                dec.imm = imm_i;
                dec.wren = 1'b1;
                dec.rden1 = 1'b1;
                dec.alu_op = arith_op;
                if (funct3 == 3'b001)
                    dec.valid = (funct7 == 7'h00);
                else if (funct3 == 3'b101)
                    dec.valid = (funct7 == 7'h00) || (funct7 == 7'h20);
                else
                    dec.valid = 1'b1;
            end
            op_reg: begin
                dec.wren = 1'b1;
                dec.rden1 = 1'b1;
                dec.rden2 = 1'b1;
                dec.alu_op = (funct3 == 3'b000 && funct7[5]) ? alu_sub : arith_op;
                dec.valid = (funct7 == 7'h00) ||
                            (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            op_fence: begin
                dec.fence = 1'b1;
                dec.valid = (funct3 == 3'b000);
            end
            op_system: begin
                dec.ecall = (instr[31:7] == 25'd0);
                dec.ebreak = (instr[31:20] == 12'd1) && (instr[19:7] == 13'd0);
                dec.valid = dec.ecall || dec.ebreak;   // csr access is not decoded here.
            end
            default: dec.valid = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_forward.sv
`default_nettype none

`include "rv_decode_macros.svh"

module rv_forward (
    rv_read_if.bypass          rd,
    input logic                ex_wren,
    input logic                ex_load,
    input logic [`RADDR_W-1:0] ex_waddr,
    input logic [`XLEN-1:0]    ex_wdata,
    input logic                wb_wren,
    input logic [`RADDR_W-1:0] wb_waddr,
    input logic [`XLEN-1:0]    wb_wdata
);
    import rv_decode_pkg::*;

    function automatic word_t pick(input logic en, input regaddr_t addr, input word_t rf);
        word_t res;
        if (!en || addr == '0)
            res = '0;
        else if (ex_wren && !ex_load && ex_waddr == addr)
            res = ex_wdata;                // load data is not ready in execute.
        else if (wb_wren && wb_waddr == addr)
            res = wb_wdata;
        else
            res = rf;
        return res;
    endfunction

    always_comb begin
        rd.data1 = pick(rd.rden1, rd.raddr1, rd.rf_data1);
        rd.data2 = pick(rd.rden2, rd.raddr2, rd.rf_data2);
    end

endmodule

`default_nettype wire

//--- logic/rv_read_if.sv
`default_nettype none

`include "rv_decode_macros.svh"

interface rv_read_if;
    logic               rden1;
    logic               rden2;
    logic [`RADDR_W-1:0] raddr1;
    logic [`RADDR_W-1:0] raddr2;
    logic [`XLEN-1:0]    rf_data1;      // raw register file output.
    logic [`XLEN-1:0]    rf_data2;
    logic [`XLEN-1:0]    data1;         // operand after bypass.
    logic [`XLEN-1:0]    data2;

    modport stage (output rden1, rden2, raddr1, raddr2, input data1, data2);
    modport regfile (input raddr1, raddr2, output rf_data1, rf_data2);
    modport bypass (input rden1, rden2, raddr1, raddr2, rf_data1, rf_data2,
                    output data1, data2);
endinterface

`default_nettype wire

//--- logic/rv_regfile.sv
`default_nettype none

`include "rv_decode_macros.svh"

module rv_regfile (
    input logic                clk,
    input logic                rst,
    rv_read_if.regfile         rd,
    input logic                wren,
    input logic [`RADDR_W-1:0] waddr,
    input logic [`XLEN-1:0]    wdata
);
    import rv_decode_pkg::*;

    word_t regs [`NREGS];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wren && waddr != '0) begin   // x0 stays zero.
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write is picked up by the bypass, not here.
    assign rd.rf_data1 = regs[rd.raddr1];
    assign rd.rf_data2 = regs[rd.raddr2];

endmodule

`default_nettype wire

//--- rv_decode.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/rv_read_if.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_forward.sv
logic/rv_decode_stage.sv
logic/rv_decode_top.sv
tb/rv_decode_asserts.sv
tb/rv_decode_tb.sv

//--- tb/rv_decode_asserts.sv
`default_nettype none

module rv_decode_asserts (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic stall,
    input logic out_valid,
    input logic out_exception,
    input logic out_wren
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fails = 0;

    // --------------------
    // control rules
    // --------------------
    flush_beats_stall: assert property (@(posedge clk) disable iff (!rst) !(stall && flush))
        else begin
            fails++;
            $error("stall and flush are high in the same cycle");
        end

    idle_after_reset: assert property (@(posedge clk) !rst |=> !out_valid)
        else begin
            fails++;
            $error("out_valid is high one cycle after reset");
        end

    trap_no_write: assert property (@(posedge clk) disable iff (!rst)
                                    out_exception |-> !out_wren)
        else begin
            fails++;
            $error("exception with out_wren high");
        end

endmodule

bind rv_decode_top rv_decode_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .flush         (flush),
    .stall         (stall),
    .out_valid     (out_valid),
    .out_exception (out_exception),
    .out_wren      (out_wren)
);

`default_nettype wire

//--- tb/rv_decode_tb.sv
`default_nettype none

module rv_decode_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_decode_pkg::*;

    localparam int N_RANDOM = 1400;
    localparam int TIMEOUT_CYCLES = 3000;    // about twice the run length.

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_pc;
    logic [31:0] in_instr;
    logic        ex_wren;
    logic        ex_load;
    logic [4:0]  ex_waddr;
    logic [31:0] ex_wdata;
    logic        wb_wren;
    logic [4:0]  wb_waddr;
    logic [31:0] wb_wdata;
    logic        flush;
    logic        stall;
    logic        out_valid;
    logic [31:0] out_pc;
    logic [31:0] out_npc;
    logic [31:0] out_imm;
    logic [4:0]  out_waddr;
    logic        out_wren;
    logic [31:0] out_rdata1;
    logic [31:0] out_rdata2;
    alu_op_t     out_alu_op;
    logic        out_load;
    logic        out_store;
    logic        out_branch;
    logic        out_jal;
    logic        out_jalr;
    logic        out_exception;
    ecause_t     out_ecause;
    logic [31:0] out_etval;

    logic [31:0] shadow [32];               // reference register file.
    logic        last_load;
    logic [4:0]  last_waddr;
    int          errors;
    int          checks;
    int          tests;
    int          cycles;

    rv_decode_top u_rv_decode_top (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("test %-10s done, %0d mismatches", name, errors - errors_before);
    endtask

    function automatic alu_op_t alu_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? alu_sub : alu_add;
            3'd1:    return alu_sll;
            3'd2:    return alu_slt;
            3'd3:    return alu_sltu;
            3'd4:    return alu_xor;
            3'd5:    return alt ? alu_sra : alu_srl;
            3'd6:    return alu_or;
            default: return alu_and;
        endcase
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $urandom;
        return r[0] ? {3'b000, r[2:1]} : r[7:3];   // low registers often, for bypass hits.
    endfunction

    // operand rule: execute result, then writeback, then register file.
    function automatic logic [31:0] operand(input logic en, input logic [4:0] addr);
        if (!en || addr == 5'd0)
            return 32'd0;
        if (ex_wren && !ex_load && ex_waddr == addr)
            return ex_wdata;
        if (wb_wren && wb_waddr == addr)
            return wb_wdata;
        return shadow[addr];
    endfunction

    // --------------------
    // stimulus
    // --------------------
    task automatic build(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, output logic [31:0] instr,
                         output decoded_t e, output logic chk_imm, output logic chk_alu);
        logic [31:0] r;
        logic [31:0] v;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r = $urandom;
        v = $urandom;
        f3 = r[14:12];
        f7 = 7'h00;
        e = '0;
        e.waddr = rd;
        e.raddr1 = rs1;
        e.raddr2 = rs2;
        e.valid = 1'b1;
        chk_imm = 1'b1;
        chk_alu = 1'b0;
        case (kind)
            0: begin
                if ((f3 == 3'd0 || f3 == 3'd5) && r[30])
                    f7 = 7'h20;
                instr = {f7, rs2, rs1, f3, rd, 7'b0110011};
                {e.wren, e.rden1, e.rden2} = 3'b111;
                e.alu_op = alu_of(f3, f7[5]);
                chk_imm = 1'b0;
                chk_alu = 1'b1;
            end
            1: begin
                if (f3 == 3'd5)
                    f7 = r[30] ? 7'h20 : 7'h00;
                else if (f3 != 3'd1)
                    f7 = v[11:5];
                instr = {f7, v[4:0], rs1, f3, rd, 7'b0010011};
                e.imm = {{20{f7[6]}}, f7, v[4:0]};
                {e.wren, e.rden1} = 2'b11;
                e.alu_op = alu_of(f3, f3 == 3'd5 && f7[5]);
                chk_alu = 1'b1;
            end
            2: begin
                if (f3 == 3'd3 || f3 > 3'd5)
                    f3 = 3'd2;
                instr = {v[11:0], rs1, f3, rd, 7'b0000011};
                e.imm = {{20{v[11]}}, v[11:0]};
                {e.wren, e.rden1, e.load} = 3'b111;
            end
            3: begin
                f3 = (r[13:12] == 2'd3) ? 3'd2 : {1'b0, r[13:12]};
                instr = {v[11:5], rs2, rs1, f3, v[4:0], 7'b0100011};
                e.imm = {{20{v[11]}}, v[11:0]};
                {e.rden1, e.rden2, e.store} = 3'b111;
            end
            4: begin
                if (f3[2:1] == 2'b01)
                    f3 = 3'd0;
                instr = {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], 7'b1100011};
                e.imm = {{19{v[12]}}, v[12:1], 1'b0};
                {e.rden1, e.rden2, e.branch} = 3'b111;
            end
            5, 6: begin
                instr = {v[31:12], rd, (kind == 5) ? 7'b0110111 : 7'b0010111};
                e.imm = {v[31:12], 12'h000};
                e.wren = 1'b1;
                e.lui = (kind == 5);
                e.auipc = (kind == 6);
                e.alu_op = alu_pass;
                chk_alu = (kind == 5);
            end
            7: begin
                instr = {v[20], v[10:1], v[11], v[19:12], rd, 7'b1101111};
                e.imm = {{11{v[20]}}, v[20:1], 1'b0};
                {e.wren, e.jal} = 2'b11;
            end
            8: begin
                instr = {v[11:0], rs1, 3'b000, rd, 7'b1100111};
                e.imm = {{20{v[11]}}, v[11:0]};
                {e.wren, e.rden1, e.jalr} = 3'b111;
            end
            default: begin
                instr = {r[31:7], 7'b1111111};   // no such major opcode.
                e.valid = 1'b0;
                chk_imm = 1'b0;
            end
        endcase
    endtask

    task automatic drive_bypass();
        ex_wren = $urandom_range(0, 1);
        ex_load = ($urandom % 4) == 0;
        ex_waddr = $urandom % 8;
        ex_wdata = $urandom;
        wb_wren = $urandom_range(0, 1);
        wb_waddr = $urandom % 8;
        wb_wdata = $urandom;
    endtask

    task automatic step();
        @(posedge clk);
        if (wb_wren && wb_waddr != 5'd0)
            shadow[wb_waddr] = wb_wdata;
        @(negedge clk);
    endtask

    task automatic idle();
        in_valid = 1'b0;
        flush = 1'b0;
        step();
        last_load = 1'b0;
    endtask

    task automatic issue(input logic [31:0] instr, input decoded_t e, input logic chk_imm,
                         input logic chk_alu, input logic do_flush);
        logic [31:0] pc;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [3:0]  cause;
        logic        st;
        logic        kill;
        logic        exc;
        logic        live;
        drive_bypass();
        pc = $urandom & 32'hffff_fffc;
        in_valid = 1'b1;
        in_pc = pc;
        in_instr = instr;
        flush = do_flush;
        d1 = operand(e.rden1, e.raddr1);
        d2 = operand(e.rden2, e.raddr2);
        st = !do_flush && last_load && last_waddr != 5'd0 &&
             ((e.rden1 && e.raddr1 == last_waddr) || (e.rden2 && e.raddr2 == last_waddr));
        kill = st || do_flush;
        exc = !e.valid || e.ebreak || e.ecall;
        live = !kill && !exc;
        cause = !e.valid ? 4'd2 : (e.ebreak ? 4'd3 : 4'd11);
        #5;
        compare("stall", st, stall);
        step();
        compare("out_valid", !kill && e.valid, out_valid);
        compare("out_exception", !kill && exc, out_exception);
        compare("out_wren", live && e.wren, out_wren);
        compare("out_load", live && e.load, out_load);
        compare("out_store", live && e.store, out_store);
        compare("out_branch", !kill && e.branch, out_branch);
        compare("out_jal", !kill && e.jal, out_jal);
        compare("out_jalr", !kill && e.jalr, out_jalr);
        if (!kill && exc) begin
            compare("out_ecause", cause, out_ecause);
            compare("out_etval", instr, out_etval);
        end
        if (live) begin
            compare("out_pc", pc, out_pc);
            compare("out_npc", pc + 32'd4, out_npc);
            compare("out_rdata1", d1, out_rdata1);
            compare("out_rdata2", d2, out_rdata2);
            if (e.wren)
                compare("out_waddr", e.waddr, out_waddr);
            if (chk_imm)
                compare("out_imm", e.imm, out_imm);
            if (chk_alu)
                compare("out_alu_op", e.alu_op, out_alu_op);
        end
        last_load = live && e.load;
        last_waddr = e.waddr;
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        int          seed;
        int          e0;
        logic [31:0] instr;
        decoded_t    e;
        logic        ci;
        logic        ca;
        seed = $urandom(32'ha46e67c2);
        clk = 1'b0;
        rst = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_instr = '0;
        flush = 1'b0;
        {ex_wren, ex_load, ex_waddr, ex_wdata} = '0;
        {wb_wren, wb_waddr, wb_wdata} = '0;
        last_load = 1'b0;
        last_waddr = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        cycles = 0;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;

        e0 = errors;
        repeat (16) @(negedge clk);
        compare("out_valid", 1'b0, out_valid);
        compare("stall", 1'b0, stall);
        compare("out_exception", 1'b0, out_exception);
        rst = 1'b1;
        @(negedge clk);
        compare("out_valid", 1'b0, out_valid);
        compare("out_exception", 1'b0, out_exception);
        finish_test("reset", e0);

        for (int i = 0; i < 33; i++) begin   // last pass writes x0.
            wb_wren = 1'b1;
            wb_waddr = i[4:0];
            wb_wdata = $urandom;
            step();
        end
        wb_wren = 1'b0;

        e0 = errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            build($urandom % 9, pick_reg(), pick_reg(), pick_reg(), instr, e, ci, ca);
            issue(instr, e, ci, ca, 1'b0);
        end
        finish_test("decode", e0);

        e0 = errors;
        idle();
        build(2, 5'd5, pick_reg(), 5'd0, instr, e, ci, ca);
        issue(instr, e, ci, ca, 1'b0);
        build(0, 5'd9, 5'd5, pick_reg(), instr, e, ci, ca);
        issue(instr, e, ci, ca, 1'b0);    // stalls, bubble out.
        issue(instr, e, ci, ca, 1'b0);    // presented again.
        idle();
        build(2, 5'd6, pick_reg(), 5'd0, instr, e, ci, ca);
        issue(instr, e, ci, ca, 1'b0);
        build(3, 5'd0, 5'd2, 5'd6, instr, e, ci, ca);
        issue(instr, e, ci, ca, 1'b0);    // hazard on the second port.
        issue(instr, e, ci, ca, 1'b0);
        finish_test("hazard", e0);

        e0 = errors;
        idle();
        build(9, 5'd0, 5'd0, 5'd0, instr, e, ci, ca);
        issue(instr, e, ci, ca, 1'b0);
        build(2, 5'd8, pick_reg(), 5'd0, instr, e, ci, ca);
        instr[14:12] = 3'b011;            // ld is an RV64 load.
        e.valid = 1'b0;
        issue(instr, e, ci, ca, 1'b0);
        e = '0;
        e.valid = 1'b1;
        e.ebreak = 1'b1;
        issue(32'h0010_0073, e, 1'b0, 1'b0, 1'b0);
        e = '0;
        e.valid = 1'b1;
        e.ecall = 1'b1;
        issue(32'h0000_0073, e, 1'b0, 1'b0, 1'b0);
        finish_test("exception", e0);

        e0 = errors;
        idle();
        build(2, 5'd7, pick_reg(), 5'd0, instr, e, ci, ca);
        issue(instr, e, ci, ca, 1'b0);
        build(0, 5'd10, 5'd7, 5'd7, instr, e, ci, ca);
        issue(instr, e, ci, ca, 1'b1);    // flush over a load-use hazard.
        build(9, 5'd0, 5'd0, 5'd0, instr, e, ci, ca);
        issue(instr, e, ci, ca, 1'b1);
        build($urandom % 9, pick_reg(), pick_reg(), pick_reg(), instr, e, ci, ca);
        issue(instr, e, ci, ca, 1'b1);
        finish_test("flush", e0);

        idle();
        idle();
        errors = errors + u_rv_decode_top.u_asserts.fails;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
